// ==== design/mvau_types_pkg.sv ====
// ##########################################################################
// MVAU type definitions
// Signed activation, weight and accumulator lanes for the datapath, plus
// the Wishbone address and data widths of the weight load port
// ##########################################################################

package mvau_types_pkg;

   // Lane widths of the quantized datapath
   localparam int ACT_W = 4;
   localparam int WGT_W = 4;
   localparam int ACC_W = 16;

   // Wishbone bus widths
   localparam int WB_ADR_W = 8;
   localparam int WB_DAT_W = 32;

   // One signed activation lane
   typedef logic signed [ACT_W-1:0] act_t;
   // One signed weight
   typedef logic signed [WGT_W-1:0] wgt_t;
   // One signed accumulator lane
   typedef logic signed [ACC_W-1:0] acc_t;

   // Wishbone word address
   typedef logic [WB_ADR_W-1:0] wb_adr_t;
   // Wishbone data word
   typedef logic [WB_DAT_W-1:0] wb_dat_t;

endpackage

// ==== design/mvau_cfg_pkg.sv ====
// ##########################################################################
// MVAU configuration defaults
// Folding factors used when the top level is built without overrides,
// and the word address layout of the Wishbone weight port
// ##########################################################################

package mvau_cfg_pkg;

   // Beats per input vector, also the input buffer depth
   localparam int DEF_SF = 4;

   // Passes per input vector, one output word each
   localparam int DEF_NF = 3;

   // Activation lanes per beat
   localparam int DEF_SIMD = 2;

   // Output lanes per word
   localparam int DEF_PE = 2;

   // Word address of weight word 0
   // Weight word n sits at WB_WMEM_BASE + n
   localparam int WB_WMEM_BASE = 0;

endpackage

// ==== design/mvau_stream_control_block.sv ====
// ##########################################################################
// MVAU stream control
// Counts beats and passes, steers the input buffer between write and
// replay, and forms the weight word address for each compute beat
// ##########################################################################

`timescale 1ns/1ps

module mvau_stream_control_block #(
   parameter int SF = mvau_cfg_pkg::DEF_SF,
   parameter int NF = mvau_cfg_pkg::DEF_NF,
   localparam int SF_T = (SF > 1) ? $clog2(SF) : 1,
   localparam int WA_W = (NF * SF > 1) ? $clog2(NF * SF) : 1
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            in_v,
   output logic            step,
   output logic            ib_wen,
   output logic            ib_ren,
   output logic            sf_clr,
   output logic [SF_T-1:0] sf_cnt,
   output logic [WA_W-1:0] wgt_addr
);

   // Last beat of the current pass
   assign sf_clr = (sf_cnt == SF_T'(SF - 1));

   generate
      if (NF == 1) begin : g_one_pass
         // Single pass, buffer is always written and never replayed
         assign ib_wen   = 1'b1;
         assign ib_ren   = 1'b0;
         assign step     = in_v;
         assign wgt_addr = WA_W'(sf_cnt);
      end else begin : g_multi_pass
         localparam int NF_T = $clog2(NF);

         // Pass counter, 0 is the write pass
         logic [NF_T-1:0] nf_cnt;
         logic            nf_last;

         assign nf_last = (nf_cnt == NF_T'(NF - 1));

         // Live input only during the first pass
         assign ib_wen = (nf_cnt == '0);
         assign ib_ren = ~ib_wen;

         // Replay runs every cycle, writing waits for in_v
         assign step = in_v | ib_ren;

         // Weight word nf_cnt*SF + sf_cnt
         assign wgt_addr = WA_W'(nf_cnt) * WA_W'(SF) + WA_W'(sf_cnt);

         always_ff @(posedge clk) begin
            if (!rst_n) begin
               nf_cnt <= '0;
            end else if (step && sf_clr) begin
               // Wrap after the final replay pass
               if (nf_last)
                  nf_cnt <= '0;
               else
                  nf_cnt <= nf_cnt + 1'b1;
            end
         end
      end
   endgenerate

   // Beat counter, stalls between steps
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sf_cnt <= '0;
      end else if (step) begin
         if (sf_clr)
            sf_cnt <= '0;
         else
            sf_cnt <= sf_cnt + 1'b1;
      end
   end

endmodule

// ==== design/mvau_input_buffer.sv ====
// ##########################################################################
// MVAU input buffer
// Holds the SF beats of one activation vector for replay and forwards
// the live beat straight to the PE array during the write pass
// ##########################################################################

`timescale 1ns/1ps

module mvau_input_buffer #(
   parameter int SF = mvau_cfg_pkg::DEF_SF,
   parameter int SIMD = mvau_cfg_pkg::DEF_SIMD,
   localparam int SF_T = (SF > 1) ? $clog2(SF) : 1
) (
   input  logic                            clk,
   input  logic                            ib_wen,
   input  logic                            step,
   input  logic [SF_T-1:0]                 sf_cnt,
   input  mvau_types_pkg::act_t [SIMD-1:0] in_data,
   output mvau_types_pkg::act_t [SIMD-1:0] act_vec
);

   // One entry per beat of the vector
   mvau_types_pkg::act_t [SIMD-1:0] line_q [SF];

   // Capture accepted beats of the write pass
   always_ff @(posedge clk) begin
      if (ib_wen && step)
         line_q[sf_cnt] <= in_data;
   end

   // Bypass during write, stored beat during replay
   always_comb begin
      if (ib_wen)
         act_vec = in_data;
      else
         act_vec = line_q[sf_cnt];
   end

endmodule

// ==== design/mvau_weight_mem.sv ====
// ##########################################################################
// MVAU weight memory
// NF*SF words of PE*SIMD packed weights, loaded and read back by the host
// over a Wishbone classic slave, read combinationally by the datapath
// ##########################################################################

`timescale 1ns/1ps

module mvau_weight_mem #(
   parameter int SF = mvau_cfg_pkg::DEF_SF,
   parameter int NF = mvau_cfg_pkg::DEF_NF,
   parameter int SIMD = mvau_cfg_pkg::DEF_SIMD,
   parameter int PE = mvau_cfg_pkg::DEF_PE,
   localparam int WA_W = (NF * SF > 1) ? $clog2(NF * SF) : 1
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               wb_cyc,
   input  logic                               wb_stb,
   input  logic                               wb_we,
   input  mvau_types_pkg::wb_adr_t            wb_adr,
   input  mvau_types_pkg::wb_dat_t            wb_dat_w,
   output logic                               wb_ack,
   output mvau_types_pkg::wb_dat_t            wb_dat_r,
   input  logic [WA_W-1:0]                    wgt_addr,
   output mvau_types_pkg::wgt_t [PE*SIMD-1:0] wgt_vec
);

   localparam int DEPTH = NF * SF;
   localparam int WORD_W = PE * SIMD * mvau_types_pkg::WGT_W;

   // Lane p, simd s at index p*SIMD+s
   typedef mvau_types_pkg::wgt_t [PE*SIMD-1:0] word_t;

   word_t mem_q [DEPTH];

   mvau_types_pkg::wb_adr_t wb_off;
   logic [WA_W-1:0]         wb_idx;
   logic                    wb_hit;
   logic                    wb_req;

   // Offset from the weight window base
   assign wb_off = wb_adr - mvau_types_pkg::wb_adr_t'(mvau_cfg_pkg::WB_WMEM_BASE);
   assign wb_hit = (wb_off < mvau_types_pkg::wb_adr_t'(DEPTH));
   assign wb_idx = wb_off[WA_W-1:0];

   // New request, one per ack
   assign wb_req = wb_cyc & wb_stb & ~wb_ack;

   // Registered single cycle ack
   always_ff @(posedge clk) begin
      if (!rst_n)
         wb_ack <= 1'b0;
      else
         wb_ack <= wb_req;
   end

   // Host write lands on the ack edge, out of range writes dropped
   always_ff @(posedge clk) begin
      if (wb_req && wb_we && wb_hit)
         mem_q[wb_idx] <= word_t'(wb_dat_w[WORD_W-1:0]);
   end

   // Read data valid together with ack
   // Unused upper bits and out of range words read as zero
   always_ff @(posedge clk) begin
      if (wb_req) begin
         if (wb_hit)
            wb_dat_r <= mvau_types_pkg::wb_dat_t'(mem_q[wb_idx]);
         else
            wb_dat_r <= '0;
      end
   end

   // Compute port, asynchronous read
   assign wgt_vec = mem_q[wgt_addr];

endmodule

// ==== design/mvau_pe_array.sv ====
// ##########################################################################
// MVAU PE array
// Two stage pipeline, SIMD dot product per PE lane, then accumulation
// across the SF beats of a pass with one output word per pass
// ##########################################################################

`timescale 1ns/1ps

module mvau_pe_array #(
   parameter int SIMD = mvau_cfg_pkg::DEF_SIMD,
   parameter int PE = mvau_cfg_pkg::DEF_PE
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               step,
   input  logic                               sf_clr,
   input  mvau_types_pkg::act_t [SIMD-1:0]    act_vec,
   input  mvau_types_pkg::wgt_t [PE*SIMD-1:0] wgt_vec,
   output logic                               out_v,
   output mvau_types_pkg::acc_t [PE-1:0]      out_data
);

   // Combinational dot products of this beat
   mvau_types_pkg::acc_t [PE-1:0] dot_c;

   // Stage 1 products and their beat flags
   mvau_types_pkg::acc_t [PE-1:0] prod_q;
   logic                          s1_v;
   logic                          s1_clr;

   // Stage 2 running sums
   mvau_types_pkg::acc_t [PE-1:0] acc_q;
   mvau_types_pkg::acc_t [PE-1:0] sum_c;

   // Signed multiply, widened to the accumulator before summing
   always_comb begin
      for (int p = 0; p < PE; p++) begin
         dot_c[p] = '0;
         for (int s = 0; s < SIMD; s++) begin
            dot_c[p] = dot_c[p]
                     + mvau_types_pkg::acc_t'(act_vec[s])
                     * mvau_types_pkg::acc_t'(wgt_vec[p*SIMD+s]);
         end
      end
   end

   // Stage 1 flags, sf_clr travels with its beat
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_v   <= 1'b0;
         s1_clr <= 1'b0;
      end else begin
         s1_v   <= step;
         s1_clr <= step & sf_clr;
      end
   end

   // Stage 1 products, held across input gaps
   always_ff @(posedge clk) begin
      if (step)
         prod_q <= dot_c;
   end

   // Accumulator plus the product in flight
   always_comb begin
      for (int p = 0; p < PE; p++)
         sum_c[p] = acc_q[p] + prod_q[p];
   end

   // Stage 2, last beat emits and restarts from zero
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc_q <= '0;
         out_v <= 1'b0;
      end else begin
         out_v <= s1_v & s1_clr;
         if (s1_v) begin
            if (s1_clr)
               acc_q <= '0;
            else
               acc_q <= sum_c;
         end
      end
   end

   // Result word of the finished pass
   always_ff @(posedge clk) begin
      if (s1_v && s1_clr)
         out_data <= sum_c;
   end

endmodule

// ==== design/mvau_stream.sv ====
// ##########################################################################
// MVAU streaming top level
// Connects control, input buffer, weight memory and PE array; one input
// vector of SF beats yields NF output words of PE accumulator lanes
// ##########################################################################

`timescale 1ns/1ps

module mvau_stream #(
   parameter int SF = mvau_cfg_pkg::DEF_SF,
   parameter int NF = mvau_cfg_pkg::DEF_NF,
   parameter int SIMD = mvau_cfg_pkg::DEF_SIMD,
   parameter int PE = mvau_cfg_pkg::DEF_PE
) (
   input  logic                            clk,
   input  logic                            rst_n,
   // Wishbone weight port
   input  logic                            wb_cyc,
   input  logic                            wb_stb,
   input  logic                            wb_we,
   input  mvau_types_pkg::wb_adr_t         wb_adr,
   input  mvau_types_pkg::wb_dat_t         wb_dat_w,
   output logic                            wb_ack,
   output mvau_types_pkg::wb_dat_t         wb_dat_r,
   // Activation stream in
   input  logic                            in_v,
   input  mvau_types_pkg::act_t [SIMD-1:0] in_data,
   output logic                            in_rdy,
   // Result stream out, no back-pressure
   output logic                            out_v,
   output mvau_types_pkg::acc_t [PE-1:0]   out_data
);

   localparam int SF_T = (SF > 1) ? $clog2(SF) : 1;
   localparam int WA_W = (NF * SF > 1) ? $clog2(NF * SF) : 1;

   logic                               step;
   logic                               ib_wen;
   logic                               sf_clr;
   logic [SF_T-1:0]                    sf_cnt;
   logic [WA_W-1:0]                    wgt_addr;
   mvau_types_pkg::act_t [SIMD-1:0]    act_vec;
   mvau_types_pkg::wgt_t [PE*SIMD-1:0] wgt_vec;

   // Beats are taken only during the write pass
   assign in_rdy = ib_wen;

   // Read enable stays internal, it drives the replay steps
   mvau_stream_control_block #(.SF(SF), .NF(NF)) i_ctrl (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_v     (in_v),
      .step     (step),
      .ib_wen   (ib_wen),
      .ib_ren   (),
      .sf_clr   (sf_clr),
      .sf_cnt   (sf_cnt),
      .wgt_addr (wgt_addr)
   );

   mvau_input_buffer #(.SF(SF), .SIMD(SIMD)) i_ibuf (
      .clk     (clk),
      .ib_wen  (ib_wen),
      .step    (step),
      .sf_cnt  (sf_cnt),
      .in_data (in_data),
      .act_vec (act_vec)
   );

   mvau_weight_mem #(.SF(SF), .NF(NF), .SIMD(SIMD), .PE(PE)) i_wmem (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_ack   (wb_ack),
      .wb_dat_r (wb_dat_r),
      .wgt_addr (wgt_addr),
      .wgt_vec  (wgt_vec)
   );

   mvau_pe_array #(.SIMD(SIMD), .PE(PE)) i_pe (
      .clk      (clk),
      .rst_n    (rst_n),
      .step     (step),
      .sf_clr   (sf_clr),
      .act_vec  (act_vec),
      .wgt_vec  (wgt_vec),
      .out_v    (out_v),
      .out_data (out_data)
   );

endmodule

// ==== sim/mvau_stream_properties.sv ====
// ##########################################################################
// MVAU stream protocol properties
// Wishbone ack shape, input handshake rule, PE pipeline latency and the
// state of the outputs right after reset
// ##########################################################################

`timescale 1ns/1ps

module mvau_stream_properties (
   input logic clk,
   input logic rst_n,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack,
   input logic in_v,
   input logic in_rdy,
   input logic step,
   input logic sf_clr,
   input logic out_v
);

   // Failed assertion count
   int unsigned fail_cnt = 0;

   // Ack answers a strobe seen on the previous edge
   ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |-> $past(wb_cyc && wb_stb))
   else begin
      fail_cnt++;
      $error("wb_ack without a preceding cyc and stb");
   end

   // Single cycle ack
   ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |=> !wb_ack)
   else begin
      fail_cnt++;
      $error("wb_ack held for two cycles");
   end

   // No beat offered during replay
   in_v_needs_rdy: assert property (@(posedge clk) disable iff (!rst_n)
      !in_rdy |-> !in_v)
   else begin
      fail_cnt++;
      $error("in_v high while in_rdy low");
   end

   // Result pulse two cycles after the last beat of a pass, and only then
   out_v_latency: assert property (@(posedge clk) disable iff (!rst_n)
      out_v == $past(step && sf_clr, 2))
   else begin
      fail_cnt++;
      $error("out_v not two cycles after the last pass beat");
   end

   out_quiet_after_reset: assert property (@(posedge clk)
      !rst_n |=> (!out_v && !wb_ack))
   else begin
      fail_cnt++;
      $error("out_v or wb_ack high after reset");
   end

endmodule

bind mvau_stream mvau_stream_properties i_props (
   .clk    (clk),
   .rst_n  (rst_n),
   .wb_cyc (wb_cyc),
   .wb_stb (wb_stb),
   .wb_ack (wb_ack),
   .in_v   (in_v),
   .in_rdy (in_rdy),
   .step   (step),
   .sf_clr (sf_clr),
   .out_v  (out_v)
);

// ==== sim/tb_mvau_stream.sv ====
// ##########################################################################
// MVAU stream testbench
// Loads weights over Wishbone, streams activation vectors and compares
// every result word with a software model of the matrix-vector product
// ##########################################################################

`timescale 1ns/1ps

module tb_mvau_stream;

   localparam int SF = mvau_cfg_pkg::DEF_SF;
   localparam int NF = mvau_cfg_pkg::DEF_NF;
   localparam int SIMD = mvau_cfg_pkg::DEF_SIMD;
   localparam int PE = mvau_cfg_pkg::DEF_PE;
   localparam int AW = mvau_types_pkg::ACC_W;
   localparam int DEPTH = NF * SF;
   localparam int WW = PE * SIMD * mvau_types_pkg::WGT_W;
   localparam int VW = SIMD * mvau_types_pkg::ACT_W;
   localparam int BASE = mvau_cfg_pkg::WB_WMEM_BASE;
   localparam int TIMEOUT = 200;
   localparam int SEED = 30365;

   logic                            clk;
   logic                            rst_n;
   logic                            wb_cyc;
   logic                            wb_stb;
   logic                            wb_we;
   mvau_types_pkg::wb_adr_t         wb_adr;
   mvau_types_pkg::wb_dat_t         wb_dat_w;
   logic                            wb_ack;
   mvau_types_pkg::wb_dat_t         wb_dat_r;
   logic                            in_v;
   mvau_types_pkg::act_t [SIMD-1:0] in_data;
   logic                            in_rdy;
   logic                            out_v;
   mvau_types_pkg::acc_t [PE-1:0]   out_data;

   // Model copy of the weights and of the vector being sent
   logic [WW-1:0]    wt [DEPTH];
   logic [VW-1:0]    vec [SF];
   // Result words still owed by the DUT, oldest first
   logic [PE*AW-1:0] expect_q [$];

   int check_errs = 0;
   int out_errs = 0;
   int got_cnt = 0;

   mvau_stream #(.SF(SF), .NF(NF), .SIMD(SIMD), .PE(PE)) i_mvau_stream (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_ack   (wb_ack),
      .wb_dat_r (wb_dat_r),
      .in_v     (in_v),
      .in_data  (in_data),
      .in_rdy   (in_rdy),
      .out_v    (out_v),
      .out_data (out_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("Timeout at %0t: %s", $time, why);
      $display("TESTBENCH FAILED");
      $finish;
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
   endtask

   // Hold the request until the slave answers
   task automatic wait_ack();
      int n = 0;
      do begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT)
            abort_run("no Wishbone ack");
      end while (!wb_ack);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_word(input int adr, input mvau_types_pkg::wb_dat_t dat);
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = mvau_types_pkg::wb_adr_t'(adr);
      wb_dat_w = dat;
      wait_ack();
   endtask

   task automatic read_word(input int adr, output mvau_types_pkg::wb_dat_t dat);
      @(negedge clk);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = mvau_types_pkg::wb_adr_t'(adr);
      wait_ack();
      dat = wb_dat_r;
   endtask

   task automatic compare_word(input int adr, input logic [31:0] got, input logic [31:0] exp);
      assert (got == exp) else begin
         check_errs++;
         $display("Mismatch at %0t: address %0d read %h, expected %h", $time, adr, got, exp);
      end
   endtask

   // Lane p of pass n, weights times activations over all beats and lanes
   function automatic logic [PE*AW-1:0] pass_result(input int n);
      logic [PE*AW-1:0] word;
      int               sum;
      word = '0;
      for (int p = 0; p < PE; p++) begin
         sum = 0;
         for (int s = 0; s < SF; s++)
            for (int k = 0; k < SIMD; k++)
               sum += int'($signed(wt[n*SF+s][(p*SIMD+k)*4 +: 4]))
                    * int'($signed(vec[s][k*4 +: 4]));
         word[p*AW +: AW] = sum[AW-1:0];
      end
      return word;
   endfunction

   // Queues the NF results unless a reset will cut the vector off
   task automatic send_vector(input bit gaps, input bit cut);
      int s = 0;
      int n = 0;
      for (int i = 0; i < SF; i++)
         vec[i] = VW'($urandom());
      if (!cut) begin
         for (int i = 0; i < NF; i++)
            expect_q.push_back(pass_result(i));
      end
      while (s < SF) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT)
            abort_run("input never became ready");
         if (in_rdy && !(gaps && $urandom_range(2, 0) == 0)) begin
            in_v    = 1'b1;
            in_data = vec[s];
            s++;
         end else begin
            in_v = 1'b0;
         end
      end
      @(negedge clk);
      in_v = 1'b0;
   endtask

   task automatic wait_outputs(input int target);
      int n = 0;
      while (got_cnt < target) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT)
            abort_run("result words did not arrive");
      end
   endtask

   // Output monitor, each pulse takes the oldest expected word
   always @(negedge clk) begin
      if (rst_n && out_v) begin
         got_cnt++;
         if (expect_q.size() == 0) begin
            out_errs++;
            $display("Unexpected output word at %0t", $time);
         end else begin
            assert (out_data == expect_q[0]) else begin
               out_errs++;
               $display("Mismatch at %0t: output %h, expected %h", $time, out_data, expect_q[0]);
            end
            void'(expect_q.pop_front());
         end
      end
   end

   initial begin : main_seq
      mvau_types_pkg::wb_dat_t rd;
      mvau_types_pkg::wb_dat_t dat;
      int                      want;
      int                      prop_errs;
      rst_n    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      in_v     = 1'b0;
      in_data  = '0;
      want     = 0;
      void'($urandom(SEED));
      apply_reset();

      // Random weights, readback keeps only the packed lanes
      for (int a = 0; a < DEPTH; a++) begin
         dat = $urandom();
         write_word(BASE + a, dat);
         wt[a] = dat[WW-1:0];
      end
      for (int a = 0; a < DEPTH; a++) begin
         read_word(BASE + a, rd);
         compare_word(BASE + a, rd, 32'(wt[a]));
      end
      write_word(BASE + DEPTH, 32'hffff_ffff);
      read_word(BASE + DEPTH, rd);
      compare_word(BASE + DEPTH, rd, 32'h0);
      read_word(255, rd);
      compare_word(255, rd, 32'h0);

      // Dense vector, then one with random input gaps
      send_vector(1'b0, 1'b0);
      want += NF;
      wait_outputs(want);
      send_vector(1'b1, 1'b0);
      want += NF;
      wait_outputs(want);

      // Back to back, each starts when in_rdy returns
      for (int v = 0; v < 3; v++)
         send_vector(1'b0, 1'b0);
      want += 3 * NF;
      wait_outputs(want);

      // Reset as the replay starts, first result still in the pipeline
      send_vector(1'b0, 1'b1);
      apply_reset();
      for (int c = 0; c < DEPTH; c++) begin
         @(negedge clk);
         assert (!out_v && in_rdy) else begin
            check_errs++;
            $display("Mismatch at %0t: out_v %b in_rdy %b after reset, expected 0 and 1",
                     $time, out_v, in_rdy);
         end
      end
      send_vector(1'b0, 1'b0);
      want += NF;
      wait_outputs(want);

      repeat (4) @(negedge clk);
      prop_errs = int'(i_mvau_stream.i_props.fail_cnt);
      $display("Errors: checks %0d, outputs %0d, properties %0d, words left %0d",
               check_errs, out_errs, prop_errs, expect_q.size());
      if (check_errs + out_errs + prop_errs == 0 && expect_q.size() == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== all.f ====
design/mvau_types_pkg.sv
design/mvau_cfg_pkg.sv
design/mvau_stream_control_block.sv
design/mvau_input_buffer.sv
design/mvau_weight_mem.sv
design/mvau_pe_array.sv
design/mvau_stream.sv
sim/mvau_stream_properties.sv
sim/tb_mvau_stream.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the MVAU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mvau_stream -f all.f

# Keep running past assertion errors so the testbench prints its summary
output=$(./obj_dir/Vtb_mvau_stream +verilator+error+limit+1000 2>&1) || true
echo "$output"

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
   exit 0
fi
exit 1
